//--- source/lsu_cfg.svh
// Queue depth, RAM size and trap cause codes of the load/store unit.
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// Request queue entries, also the number of issue credits.
`define LSU_QUEUE_DEPTH 4

// Data RAM size in 32-bit words, a power of two.
`define LSU_RAM_WORDS 64

// Misaligned load.
`define LSU_CAUSE_LALIGN 4

// Misaligned store.
`define LSU_CAUSE_SALIGN 6

`endif

//--- source/lsu_op_pkg.sv
// Access-level types: access size and trap cause.
package lsu_op_pkg;

    // Access size, encoded as funct3[1:0] of the RISC-V load and store opcodes.
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } access_size_t;

    // Trap cause code, as in mcause.
    typedef logic [3:0] cause_t;

endpackage

//--- source/dbus_pkg.sv
// Bus-level types: data word, address, strobes, lane, credit count, queue pointer.
`include "lsu_cfg.svh"

package dbus_pkg;

    // One 32-bit data word.
    typedef logic [31:0] word_t;

    // Byte address, or word address once the lane bits are dropped.
    typedef logic [31:0] addr_t;

    // Byte write strobes, one per lane.
    typedef logic [3:0] strb_t;

    // Byte offset within a word.
    typedef logic [1:0] lane_t;

    // Credit counter, holds 0 to LSU_QUEUE_DEPTH.
    typedef logic [$clog2(`LSU_QUEUE_DEPTH + 1)-1:0] credit_t;

    // Request queue pointer.
    typedef logic [$clog2(`LSU_QUEUE_DEPTH)-1:0] qptr_t;

endpackage

//--- source/mem_req_if.sv
// Memory request link: one request, its valid and its take, with sender and receiver modports.
`timescale 1ns/1ps

interface mem_req_if;
    import lsu_op_pkg::*;
    import dbus_pkg::*;

    // Handshake.
    logic         valid;
    logic         take;

    // Request fields.
    logic         write;
    logic         trap;
    cause_t       cause;
    addr_t        word_addr;
    strb_t        strb;
    word_t        wdata;
    access_size_t size;
    lane_t        lane;
    logic         is_unsigned;

    // Side that offers requests.
    modport sender (
        output valid, write, trap, cause, word_addr, strb, wdata, size, lane,
        output is_unsigned,
        input  take
    );

    // Side that consumes requests, one take pulse per item freed.
    modport receiver (
        input  valid, write, trap, cause, word_addr, strb, wdata, size, lane,
        input  is_unsigned,
        output take
    );

endinterface

//--- source/access_issuer.sv
// Access issuer: command acceptance, alignment check, strobes, lanes and credit counter.
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module access_issuer (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     cmd_valid,
    output logic                     cmd_ready,
    input  logic                     cmd_write,
    input  lsu_op_pkg::access_size_t cmd_size,
    input  logic                     cmd_unsigned,
    input  dbus_pkg::addr_t          cmd_addr,
    input  dbus_pkg::word_t          cmd_wdata,
    mem_req_if.sender                req
);
    import lsu_op_pkg::*;
    import dbus_pkg::*;

    credit_t credits;
    credit_t credits_free;
    logic    accept;
    lane_t   lane;
    logic    misaligned;
    strb_t   strb;
    word_t   wdata_rep;
    cause_t  align_cause;

    // The request on the link still holds its credit.
    assign credits_free = credits - credit_t'(req.valid);
    assign cmd_ready    = (credits_free != '0);
    assign accept       = cmd_valid && cmd_ready;
    assign lane         = cmd_addr[1:0];
    assign align_cause  = cmd_write ? cause_t'(`LSU_CAUSE_SALIGN) : cause_t'(`LSU_CAUSE_LALIGN);

    // Alignment, byte lanes and write data replication per size.
    always_comb begin
        case (cmd_size)
            SIZE_BYTE: begin
                misaligned = 1'b0;
                strb       = strb_t'(4'b0001 << lane);
                wdata_rep  = {4{cmd_wdata[7:0]}};
            end
            SIZE_HALF: begin
                misaligned = lane[0];
                strb       = lane[1] ? 4'b1100 : 4'b0011;
                wdata_rep  = {2{cmd_wdata[15:0]}};
            end
            default: begin
                misaligned = (lane != 2'b00);
                strb       = 4'b1111;
                wdata_rep  = cmd_wdata;
            end
        endcase
    end

    // One-cycle valid per accepted command.
    always_ff @(posedge clk) begin
        if (rst) begin
            req.valid <= 1'b0;
        end else begin
            req.valid <= accept;
        end
    end

    // Request payload.
    always_ff @(posedge clk) begin
        if (accept) begin
            req.write       <= cmd_write;
            req.trap        <= misaligned;
            req.cause       <= misaligned ? align_cause : '0;
            req.word_addr   <= {2'b00, cmd_addr[31:2]};
            // Loads and traps leave memory alone.
            req.strb        <= (cmd_write && !misaligned) ? strb : '0;
            req.wdata       <= wdata_rep;
            req.size        <= cmd_size;
            req.lane        <= lane;
            req.is_unsigned <= cmd_unsigned;
        end
    end

    // Spend on each valid cycle, regain on each take.
    always_ff @(posedge clk) begin
        if (rst) begin
            credits <= credit_t'(`LSU_QUEUE_DEPTH);
        end else begin
            credits <= credits_free + credit_t'(req.take);
        end
    end

endmodule

//--- source/request_queue.sv
// Request queue: circular FIFO of memory requests, one credit returned per pop.
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module request_queue (
    input  logic        clk,
    input  logic        rst,
    mem_req_if.receiver push,
    mem_req_if.sender   pop
);
    import lsu_op_pkg::*;
    import dbus_pkg::*;

    // Entry storage, one array per field.
    logic         write_q    [`LSU_QUEUE_DEPTH];
    logic         trap_q     [`LSU_QUEUE_DEPTH];
    cause_t       cause_q    [`LSU_QUEUE_DEPTH];
    addr_t        addr_q     [`LSU_QUEUE_DEPTH];
    strb_t        strb_q     [`LSU_QUEUE_DEPTH];
    word_t        wdata_q    [`LSU_QUEUE_DEPTH];
    access_size_t size_q     [`LSU_QUEUE_DEPTH];
    lane_t        lane_q     [`LSU_QUEUE_DEPTH];
    logic         unsigned_q [`LSU_QUEUE_DEPTH];

    qptr_t   wptr;
    qptr_t   rptr;
    credit_t count;

    // Wraps at the queue depth, which need not be a power of two.
    function automatic qptr_t ptr_next(input qptr_t ptr);
        if (ptr == qptr_t'(`LSU_QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    // Credits guarantee a free slot for every push.
    always_ff @(posedge clk) begin
        if (push.valid) begin
            write_q[wptr]    <= push.write;
            trap_q[wptr]     <= push.trap;
            cause_q[wptr]    <= push.cause;
            addr_q[wptr]     <= push.word_addr;
            strb_q[wptr]     <= push.strb;
            wdata_q[wptr]    <= push.wdata;
            size_q[wptr]     <= push.size;
            lane_q[wptr]     <= push.lane;
            unsigned_q[wptr] <= push.is_unsigned;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (push.valid) begin
                wptr <= ptr_next(wptr);
            end
            if (pop.take) begin
                rptr <= ptr_next(rptr);
            end
            count <= count + credit_t'(push.valid) - credit_t'(pop.take);
        end
    end

    // Head of queue.
    assign pop.valid       = (count != '0);
    assign pop.write       = write_q[rptr];
    assign pop.trap        = trap_q[rptr];
    assign pop.cause       = cause_q[rptr];
    assign pop.word_addr   = addr_q[rptr];
    assign pop.strb        = strb_q[rptr];
    assign pop.wdata       = wdata_q[rptr];
    assign pop.size        = size_q[rptr];
    assign pop.lane        = lane_q[rptr];
    assign pop.is_unsigned = unsigned_q[rptr];

    // A pop frees a slot, so it returns a credit.
    assign push.take = pop.take;

endmodule

//--- source/data_ram.sv
// Data RAM: word array, request execution, load extraction and extension, response register.
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module data_ram (
    input  logic               clk,
    input  logic               rst,
    mem_req_if.receiver        req,
    output logic               rsp_valid,
    input  logic               rsp_ready,
    output dbus_pkg::word_t    rsp_rdata,
    output logic               rsp_trap,
    output lsu_op_pkg::cause_t rsp_cause
);
    import lsu_op_pkg::*;
    import dbus_pkg::*;

    word_t mem [`LSU_RAM_WORDS];

    logic [$clog2(`LSU_RAM_WORDS)-1:0] idx;
    logic        pop;
    logic        do_store;
    word_t       rd_word;
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    word_t       load_data;

    // Word address wraps modulo the RAM size.
    assign idx = req.word_addr[$clog2(`LSU_RAM_WORDS)-1:0];

    // Pop while the response slot is free or draining.
    assign pop      = req.valid && (!rsp_valid || rsp_ready);
    assign req.take = pop;
    assign do_store = pop && req.write && !req.trap;

    assign rd_word  = mem[idx];
    assign byte_sel = rd_word[8*req.lane +: 8];
    assign half_sel = req.lane[1] ? rd_word[31:16] : rd_word[15:0];

    // Sign or zero extension of the selected lanes.
    always_comb begin
        case (req.size)
            SIZE_BYTE: begin
                load_data = {{24{byte_sel[7] && !req.is_unsigned}}, byte_sel};
            end
            SIZE_HALF: begin
                load_data = {{16{half_sel[15] && !req.is_unsigned}}, half_sel};
            end
            default: begin
                load_data = rd_word;
            end
        endcase
    end

    // Byte-strobed store.
    always_ff @(posedge clk) begin
        if (do_store) begin
            for (int b = 0; b < 4; b++) begin
                if (req.strb[b]) begin
                    mem[idx][8*b +: 8] <= req.wdata[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rsp_valid <= 1'b0;
        end else if (pop) begin
            rsp_valid <= 1'b1;
        end else if (rsp_ready) begin
            rsp_valid <= 1'b0;
        end
    end

    // Response payload, loaded only on a pop so it holds under back-pressure.
    always_ff @(posedge clk) begin
        if (pop) begin
            rsp_trap  <= req.trap;
            rsp_cause <= req.cause;
            rsp_rdata <= (req.write || req.trap) ? '0 : load_data;
        end
    end

endmodule

//--- source/lsu_top.sv
// Load/store unit top level: issuer, request queue and data RAM on two request links.
`timescale 1ns/1ps

module lsu_top (
    input  logic                     clk,
    input  logic                     rst,

    // Command side.
    input  logic                     cmd_valid,
    output logic                     cmd_ready,
    input  logic                     cmd_write,
    input  lsu_op_pkg::access_size_t cmd_size,
    input  logic                     cmd_unsigned,
    input  dbus_pkg::addr_t          cmd_addr,
    input  dbus_pkg::word_t          cmd_wdata,

    // Response side.
    output logic                     rsp_valid,
    input  logic                     rsp_ready,
    output dbus_pkg::word_t          rsp_rdata,
    output logic                     rsp_trap,
    output lsu_op_pkg::cause_t       rsp_cause
);

    // Issuer to queue, credit based.
    mem_req_if issue_link ();

    // Queue head to RAM.
    mem_req_if head_link ();

    access_issuer u_issuer (
        .clk          (clk),
        .rst          (rst),
        .cmd_valid    (cmd_valid),
        .cmd_ready    (cmd_ready),
        .cmd_write    (cmd_write),
        .cmd_size     (cmd_size),
        .cmd_unsigned (cmd_unsigned),
        .cmd_addr     (cmd_addr),
        .cmd_wdata    (cmd_wdata),
        .req          (issue_link.sender)
    );

    request_queue u_queue (
        .clk  (clk),
        .rst  (rst),
        .push (issue_link.receiver),
        .pop  (head_link.sender)
    );

    data_ram u_ram (
        .clk       (clk),
        .rst       (rst),
        .req       (head_link.receiver),
        .rsp_valid (rsp_valid),
        .rsp_ready (rsp_ready),
        .rsp_rdata (rsp_rdata),
        .rsp_trap  (rsp_trap),
        .rsp_cause (rsp_cause)
    );

endmodule

//--- bench/lsu_asserts.sv
// Concurrent assertions on credits, queue occupancy and response stability, bound into lsu_top.
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_asserts (
    input logic               clk,
    input logic               rst,
    input dbus_pkg::credit_t  q_count,
    input dbus_pkg::credit_t  credits,
    input logic               issue_valid,
    input logic               rsp_valid,
    input logic               rsp_ready,
    input dbus_pkg::word_t    rsp_rdata,
    input logic               rsp_trap,
    input lsu_op_pkg::cause_t rsp_cause
);
    import dbus_pkg::*;

    // Number of assertion failures seen.
    int fail_count = 0;

    a_queue_count: assert property (@(posedge clk) disable iff (rst)
        q_count <= credit_t'(`LSU_QUEUE_DEPTH))
        else begin
            $error("queue count above depth");
            fail_count++;
        end

    a_credit_max: assert property (@(posedge clk) disable iff (rst)
        credits <= credit_t'(`LSU_QUEUE_DEPTH))
        else begin
            $error("credit counter above depth");
            fail_count++;
        end

    // A request on the link holds one credit.
    a_issue_credit: assert property (@(posedge clk) disable iff (rst)
        issue_valid |-> credits != '0)
        else begin
            $error("issue valid without a credit");
            fail_count++;
        end

    a_rsp_stable: assert property (@(posedge clk) disable iff (rst)
        (rsp_valid && !rsp_ready) |=> (rsp_valid && $stable(rsp_rdata)
            && $stable(rsp_trap) && $stable(rsp_cause)))
        else begin
            $error("response changed under back-pressure");
            fail_count++;
        end

endmodule

bind lsu_top lsu_asserts chk (
    .clk         (clk),
    .rst         (rst),
    .q_count     (u_queue.count),
    .credits     (u_issuer.credits),
    .issue_valid (issue_link.valid),
    .rsp_valid   (rsp_valid),
    .rsp_ready   (rsp_ready),
    .rsp_rdata   (rsp_rdata),
    .rsp_trap    (rsp_trap),
    .rsp_cause   (rsp_cause)
);

//--- bench/lsu_tb.sv
// Testbench for lsu_top: clock, reset, reference memory, compare tasks, directed tests, timeout.
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_tb;
    import lsu_op_pkg::*;
    import dbus_pkg::*;

    localparam int TOTAL_CMDS     = 330;
    localparam int CYCLES_PER_CMD = 40;
    localparam int CYCLE_LIMIT    = TOTAL_CMDS * CYCLES_PER_CMD + 100;

    logic clk, rst, cmd_valid, cmd_ready, cmd_write, cmd_unsigned;
    access_size_t cmd_size;
    addr_t  cmd_addr;
    word_t  cmd_wdata, rsp_rdata;
    logic   rsp_valid, rsp_ready, rsp_trap;
    cause_t rsp_cause;

    logic [7:0]  ref_mem [`LSU_RAM_WORDS * 4];
    word_t       exp_data [$];
    logic        exp_trap [$];
    cause_t      exp_cause [$];
    logic [31:0] stim_state, rdy_state;
    int          rdy_mode;
    logic        rand_valid;
    int          cycles;

    lsu_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(inout logic [31:0] s);
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        return s;
    endfunction

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) stop_on_error($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic compare_cause(input string name, input cause_t got, input cause_t exp);
        if (got !== exp) stop_on_error($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) stop_on_error($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
    endtask

    // Reference: alignment, lane writes and extension, in command order.
    task automatic model_access(input logic wr, input access_size_t sz, input logic uns,
                                input addr_t addr, input word_t wd);
        int    n;
        int    base;
        word_t val;
        n = (sz == SIZE_BYTE) ? 1 : (sz == SIZE_HALF) ? 2 : 4;
        base = ((addr >> 2) % `LSU_RAM_WORDS) * 4 + addr[1:0];
        val = '0;
        if ((addr[1:0] % n) != 0) begin
            exp_data.push_back('0);
            exp_trap.push_back(1'b1);
            exp_cause.push_back(wr ? cause_t'(`LSU_CAUSE_SALIGN) : cause_t'(`LSU_CAUSE_LALIGN));
        end else begin
            for (int i = 0; i < n; i++) begin
                if (wr) ref_mem[base + i] = wd[8*i +: 8];
                else val[8*i +: 8] = ref_mem[base + i];
            end
            if (!wr && !uns && n < 4 && val[8*n-1]) begin
                for (int i = n; i < 4; i++) val[8*i +: 8] = 8'hff;
            end
            exp_data.push_back(val);
            exp_trap.push_back(1'b0);
            exp_cause.push_back('0);
        end
    endtask

    // Drives one command on falling edges until it is accepted.
    task automatic issue(input logic wr, input access_size_t sz, input logic uns,
                         input addr_t addr, input word_t wd);
        logic [31:0] r;
        logic        done;
        done = 1'b0;
        while (!done) begin
            @(negedge clk);
            r = xorshift(stim_state);
            if (rand_valid && r[1:0] == 2'b00) begin
                cmd_valid = 1'b0;
            end else begin
                cmd_valid    = 1'b1;
                cmd_write    = wr;
                cmd_size     = sz;
                cmd_unsigned = uns;
                cmd_addr     = addr;
                cmd_wdata    = wd;
                if (cmd_ready) begin
                    model_access(wr, sz, uns, addr, wd);
                    done = 1'b1;
                end
            end
        end
    endtask

    task automatic drain();
        @(negedge clk);
        cmd_valid = 1'b0;
        while (exp_data.size() != 0) @(negedge clk);
        @(negedge clk);
    endtask

    // Response side: set ready, then check a response that completes at the next edge.
    always @(negedge clk) begin
        if (!rst) begin
            if (rdy_mode == 1) rsp_ready = xorshift(rdy_state) > 32'h6000_0000;
            else rsp_ready = (rdy_mode == 0);
            if (rsp_valid && rsp_ready) begin
                if (exp_data.size() == 0) stop_on_error("Response arrived with no command pending.");
                compare_word("rsp_rdata", rsp_rdata, exp_data.pop_front());
                compare_bit("rsp_trap", rsp_trap, exp_trap.pop_front());
                compare_cause("rsp_cause", rsp_cause, exp_cause.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT) stop_on_error("Timeout: the run exceeded its cycle limit.");
        if (uut.chk.fail_count != 0) stop_on_error("A bound assertion failed.");
    end

    task automatic init_ram();
        for (int i = 0; i < `LSU_RAM_WORDS; i++) begin
            issue(1'b1, SIZE_WORD, 1'b0, addr_t'(i * 4), 32'h9e37_79b9 * (i + 1) ^ i);
        end
        drain();
    endtask

    task automatic test_word_roundtrip();
        for (int i = 0; i < 8; i++) issue(1'b1, SIZE_WORD, 1'b0, addr_t'(i * 20), 32'hA5A5_0000 + i);
        for (int i = 0; i < 8; i++) issue(1'b0, SIZE_WORD, 1'b0, addr_t'(i * 20), '0);
        drain();
    endtask

    task automatic test_subword();
        issue(1'b1, SIZE_WORD, 1'b0, 32'h40, 32'h1122_3344);
        for (int l = 0; l < 4; l++) begin
            issue(1'b1, SIZE_BYTE, 1'b0, addr_t'(32'h40 + l), 32'h80 | (l * 32'h11));
            issue(1'b0, SIZE_WORD, 1'b0, 32'h40, '0);
        end
        issue(1'b1, SIZE_HALF, 1'b0, 32'h42, 32'h0000_BEEF);
        issue(1'b0, SIZE_WORD, 1'b0, 32'h40, '0);
        issue(1'b1, SIZE_HALF, 1'b0, 32'h40, 32'h0000_7F01);
        issue(1'b0, SIZE_WORD, 1'b0, 32'h40, '0);
        for (int l = 0; l < 4; l++) begin
            issue(1'b0, SIZE_BYTE, 1'b0, addr_t'(32'h40 + l), '0);
            issue(1'b0, SIZE_BYTE, 1'b1, addr_t'(32'h40 + l), '0);
        end
        for (int l = 0; l < 4; l += 2) begin
            issue(1'b0, SIZE_HALF, 1'b0, addr_t'(32'h40 + l), '0);
            issue(1'b0, SIZE_HALF, 1'b1, addr_t'(32'h40 + l), '0);
        end
        drain();
    endtask

    task automatic test_misaligned();
        issue(1'b1, SIZE_WORD, 1'b0, 32'h80, 32'hCAFE_F00D);
        issue(1'b1, SIZE_HALF, 1'b0, 32'h81, 32'h1234_5678);
        issue(1'b1, SIZE_HALF, 1'b0, 32'h83, 32'h1234_5678);
        for (int o = 1; o < 4; o++) issue(1'b1, SIZE_WORD, 1'b0, addr_t'(32'h80 + o), 32'hFFFF_FFFF);
        issue(1'b0, SIZE_HALF, 1'b0, 32'h81, '0);
        issue(1'b0, SIZE_WORD, 1'b0, 32'h82, '0);
        issue(1'b0, SIZE_WORD, 1'b0, 32'h80, '0);
        drain();
    endtask

    task automatic test_backpressure();
        int n;
        n = 0;
        rdy_mode = 2;
        for (int i = 0; i < `LSU_QUEUE_DEPTH + 3; i++) begin
            @(negedge clk);
            cmd_valid = 1'b1;
            cmd_write = i[0];
            cmd_size  = SIZE_WORD;
            cmd_addr  = addr_t'(32'hC0 + 4 * (i / 2));
            cmd_wdata = 32'h5000_0000 + i;
            if (!cmd_ready) break;
            model_access(cmd_write, cmd_size, 1'b0, cmd_addr, cmd_wdata);
            n++;
        end
        compare_bit("cmd_ready", cmd_ready, 1'b0);
        compare_word("accepted commands", word_t'(n), word_t'(`LSU_QUEUE_DEPTH + 1));
        cmd_valid = 1'b0;
        rdy_mode = 0;
        drain();
    endtask

    task automatic test_latency();
        issue(1'b0, SIZE_WORD, 1'b0, 32'h40, '0);
        @(negedge clk);
        cmd_valid = 1'b0;
        compare_bit("rsp_valid", rsp_valid, 1'b0);
        @(negedge clk);
        compare_bit("rsp_valid", rsp_valid, 1'b0);
        @(negedge clk);
        compare_bit("rsp_valid", rsp_valid, 1'b1);
        drain();
    endtask

    task automatic test_random_stream();
        logic [31:0] a;
        logic [31:0] r;
        access_size_t sz;
        rdy_mode = 1;
        rand_valid = 1'b1;
        for (int i = 0; i < 200; i++) begin
            a = xorshift(stim_state);
            r = xorshift(stim_state);
            sz = (r[1:0] == 2'b00) ? SIZE_BYTE : (r[1:0] == 2'b01) ? SIZE_HALF : SIZE_WORD;
            // Aligned most of the time so that stores land.
            if (r[3]) begin
                a[1:0] = (sz == SIZE_WORD) ? 2'b00 :
                         (sz == SIZE_HALF) ? {a[1], 1'b0} : a[1:0];
            end
            issue(r[4], sz, r[5], a, xorshift(stim_state));
        end
        rand_valid = 1'b0;
        rdy_mode = 0;
        drain();
    endtask

    initial begin
        stim_state = 32'd37318;
        rdy_state = 32'd37318 * 3;
        rdy_mode = 0;
        rand_valid = 1'b0;
        cycles = 0;
        rst = 1'b1;
        cmd_valid = 1'b0;
        cmd_write = 1'b0;
        cmd_size = SIZE_WORD;
        cmd_unsigned = 1'b0;
        cmd_addr = '0;
        cmd_wdata = '0;
        rsp_ready = 1'b1;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        init_ram();
        test_word_roundtrip();
        test_subword();
        test_misaligned();
        test_backpressure();
        test_latency();
        test_random_stream();
        if (uut.chk.fail_count != 0) begin
            stop_on_error("A bound assertion failed.");
        end else if (exp_data.size() != 0) begin
            stop_on_error("Responses still outstanding at end of run.");
        end else begin
            $display("SIMULATION PASSED");
            $finish;
        end
    end

endmodule

//--- project.f
+incdir+source
source/lsu_op_pkg.sv
source/dbus_pkg.sv
source/mem_req_if.sv
source/access_issuer.sv
source/request_queue.sv
source/data_ram.sv
source/lsu_top.sv
bench/lsu_asserts.sv
bench/lsu_tb.sv

//--- Bender.yml
package:
  name: lsu

export_include_dirs:
  - source

sources:
  - include_dirs:
      - source
    files:
      - source/lsu_op_pkg.sv
      - source/dbus_pkg.sv
      - source/mem_req_if.sv
      - source/access_issuer.sv
      - source/request_queue.sv
      - source/data_ram.sv
      - source/lsu_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - bench/lsu_asserts.sv
      - bench/lsu_tb.sv
